// File: verilog.f
+incdir+.
bpu_pkg.sv
inst_classify.sv
pred_table.sv
btb.sv
bimodal_predictor.sv
return_stack.sv
next_pc_select.sv
bpu_top.sv
tb_bpu.sv

// File: tb_bpu.sv
`timescale 1ns/10ps
`include "bpu_defines.svh"

module tb_bpu;
    import bpu_pkg::*;

    localparam logic [31:0] INST_ADDI = 32'h00108093;

    logic                   clk;
    logic                   rst;
    logic                   stall_i;
    logic                   flush_i;
    fetch_t                 fetch_i;
    resolve_t               resolve_i;
    prediction_t            pred_o;
    logic [`BPU_HIST_W-1:0] history_o;

    integer seed = 32'hf51d2cee;
    integer tests = 0;
    integer checks = 0;
    integer errors = 0;
    integer test_err_base = 0;

    bpu_top u_bpu_top (
        .clk       (clk),
        .rst       (rst),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .fetch_i   (fetch_i),
        .resolve_i (resolve_i),
        .pred_o    (pred_o),
        .history_o (history_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rv32 encoders for the instructions under test
    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        enc_jal = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        enc_jalr = {12'd0, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        enc_branch = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] rand_word_pc();
        rand_word_pc = $random(seed) & 32'hffff_fffc;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        stall_i   <= 1'b0;
        flush_i   <= 1'b0;
        resolve_i <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    // fetch presents one instruction, the prediction is sampled mid cycle
    task automatic fetch_inst(input logic [31:0] pc, input logic [31:0] inst);
        @(posedge clk);
        fetch_i.pc   <= pc;
        fetch_i.inst <= inst;
        @(negedge clk);
    endtask

    task automatic send_resolve(input logic [31:0] pc, input logic [31:0] inst,
                                input logic taken, input logic mispredict,
                                input logic [31:0] target);
        resolve_t r;
        r            = '0;
        r.valid      = 1'b1;
        r.taken      = taken;
        r.mispredict = mispredict;
        r.pc         = pc;
        r.inst       = inst;
        r.target     = target;
        @(posedge clk);
        resolve_i <= r;
        @(posedge clk);
        resolve_i.valid <= 1'b0;
    endtask

    task automatic check_pred(input logic is_ctl, input logic taken,
                              input logic [31:0] target, input string what);
        checks = checks + 1;
        assert (pred_o.is_ctl === is_ctl && pred_o.taken === taken && pred_o.target === target)
        else begin
            $display("error at %0t: %s: got ctl %b taken %b target %h, expected %b %b %h",
                     $time, what, pred_o.is_ctl, pred_o.taken, pred_o.target,
                     is_ctl, taken, target);
            errors = errors + 1;
        end
    endtask

    task automatic check_history(input logic [`BPU_HIST_W-1:0] exp, input string what);
        checks = checks + 1;
        assert (history_o === exp)
        else begin
            $display("error at %0t: %s: history %h, expected %h", $time, what, history_o, exp);
            errors = errors + 1;
        end
    endtask

    task automatic end_test(input string name);
        tests = tests + 1;
        $display("test %0d %s: done, %0d errors", tests, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    initial begin
        logic [31:0]            pc;
        logic [31:0]            p1;
        logic [31:0]            p2;
        logic [31:0]            tgt;
        logic [20:0]            joff;
        logic [12:0]            boff;
        logic [31:0]            binst;
        logic                   tk;
        logic [`BPU_HIST_W-1:0] hist;
        logic [`BPU_HIST_W-1:0] snap;

        rst       = 1'b1;
        stall_i   = 1'b0;
        flush_i   = 1'b0;
        fetch_i   = '0;
        resolve_i = '0;

        // reset and plain instructions
        apply_reset();
        check_history('0, "history after reset");
        pc = rand_word_pc();
        fetch_inst(pc, INST_ADDI);
        check_pred(1'b0, 1'b0, pc + 4, "non-control instruction");
        joff = $random(seed) & 21'h1ffffe;
        fetch_inst(pc, enc_jal(5'd1, joff));
        check_pred(1'b1, 1'b1, pc + {{11{joff[20]}}, joff}, "jal target");
        end_test("reset and plain instructions");

        // counter training, target taken from the btb once filled
        apply_reset();
        pc    = rand_word_pc();
        boff  = $random(seed) & 13'h1ffe;
        binst = enc_branch(boff);
        tgt   = pc + {{19{boff[12]}}, boff} + 32'h40;
        fetch_inst(pc, binst);
        check_pred(1'b1, 1'b0, pc + 4, "fresh branch");
        send_resolve(pc, binst, 1'b1, 1'b1, tgt);
        send_resolve(pc, binst, 1'b1, 1'b1, tgt);
        fetch_inst(pc, binst);
        check_pred(1'b1, 1'b1, tgt, "branch after two taken resolves");
        send_resolve(pc, binst, 1'b0, 1'b1, pc + 4);
        fetch_inst(pc, binst);
        check_pred(1'b1, 1'b1, tgt, "branch after one not-taken resolve");
        send_resolve(pc, binst, 1'b0, 1'b1, pc + 4);
        fetch_inst(pc, binst);
        check_pred(1'b1, 1'b0, pc + 4, "branch after two not-taken resolves");
        end_test("branch counter training");

        // indirect jumps
        apply_reset();
        pc  = rand_word_pc();
        tgt = rand_word_pc();
        fetch_inst(pc, enc_jalr(5'd5, 5'd6));
        check_pred(1'b1, 1'b0, pc + 4, "jalr without btb entry");
        send_resolve(pc, enc_jalr(5'd5, 5'd6), 1'b1, 1'b1, tgt);
        fetch_inst(pc, enc_jalr(5'd5, 5'd6));
        check_pred(1'b1, 1'b1, tgt, "jalr after taken resolve");
        end_test("indirect jumps");

        // return stack, pcs spread over distinct btb rows
        apply_reset();
        p1 = $random(seed) & 32'hffff_fc00;
        p2 = p1 + 32'h100;
        pc = p1 + 32'h200;
        send_resolve(p1, enc_jalr(5'd1, 5'd5), 1'b1, 1'b1, rand_word_pc());
        send_resolve(p2, enc_jal(5'd1, 21'h000100), 1'b1, 1'b0, p2 + 32'h100);
        fetch_inst(pc, enc_jalr(5'd0, 5'd1));
        check_pred(1'b1, 1'b1, p2 + 4, "return after two calls");
        send_resolve(pc, enc_jalr(5'd0, 5'd1), 1'b1, 1'b0, p2 + 4);
        fetch_inst(pc, enc_jalr(5'd0, 5'd1));
        check_pred(1'b1, 1'b1, p1 + 4, "return after one pop");
        send_resolve(pc, enc_jalr(5'd0, 5'd1), 1'b1, 1'b0, p1 + 4);
        fetch_inst(p1 + 32'h300, enc_jalr(5'd0, 5'd1));
        check_pred(1'b1, 1'b1, 32'h0, "return on empty stack");
        end_test("return stack");

        // history, stall and flush
        apply_reset();
        hist = '0;
        pc   = rand_word_pc();
        for (int i = 0; i < 6; i++) begin
            tk = $random(seed);
            send_resolve(pc + 32'(i * 4), enc_branch(13'h010), tk, 1'b0, pc + 32'h10);
            hist = {hist[`BPU_HIST_W-2:0], tk};
            @(negedge clk);
            check_history(hist, "history shift");
        end
        p1 = pc + 32'h200;
        @(posedge clk);
        stall_i         <= 1'b1;
        resolve_i.valid <= 1'b1;
        resolve_i.taken <= 1'b1;
        resolve_i.pc    <= p1;
        resolve_i.inst  <= enc_jalr(5'd5, 5'd6);
        fetch_i.pc      <= pc;
        fetch_i.inst    <= enc_jal(5'd1, 21'h000040);
        @(negedge clk);
        check_pred(1'b0, 1'b0, pc + 4, "prediction masked by stall");
        @(posedge clk);
        stall_i         <= 1'b0;
        resolve_i.valid <= 1'b0;
        @(negedge clk);
        check_history(hist, "history held under stall");
        fetch_inst(p1, enc_jalr(5'd5, 5'd6));
        check_pred(1'b1, 1'b0, p1 + 4, "no btb fill under stall");
        snap = $random(seed);
        @(posedge clk);
        flush_i           <= 1'b1;
        resolve_i.valid   <= 1'b1;
        resolve_i.history <= snap;
        fetch_i.pc        <= pc;
        fetch_i.inst      <= enc_jal(5'd1, 21'h000040);
        @(negedge clk);
        check_pred(1'b0, 1'b0, pc + 4, "prediction masked by flush");
        @(posedge clk);
        flush_i         <= 1'b0;
        resolve_i.valid <= 1'b0;
        @(negedge clk);
        check_history(snap, "history restored by flush");
        end_test("history, flush and stall");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bpu_top.sv
`timescale 1ns/10ps
`include "bpu_defines.svh"

module bpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  bpu_pkg::fetch_t        fetch_i,
    input  bpu_pkg::resolve_t      resolve_i,
    output bpu_pkg::prediction_t   pred_o,
    output logic [`BPU_HIST_W-1:0] history_o
);
    import bpu_pkg::*;

    localparam logic [`BPU_XLEN-1:0] INST_STEP = 4;

    inst_info_t             fetch_info;
    inst_info_t             res_info;
    logic                   upd_ok;
    logic                   btb_hit;
    logic [`BPU_XLEN-1:0]   btb_target;
    logic                   bim_taken;
    logic                   ras_valid;
    logic [`BPU_XLEN-1:0]   ras_top;
    logic [`BPU_HIST_W-1:0] hist_q;

    // a resolve only trains when the pipeline is moving
    assign upd_ok = resolve_i.valid && !stall_i && !flush_i;

    inst_classify u_fetch_classify (
        .inst_i (fetch_i.inst),
        .info_o (fetch_info)
    );

    inst_classify u_resolve_classify (
        .inst_i (resolve_i.inst),
        .info_o (res_info)
    );

    btb u_btb (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc_i   (fetch_i.pc),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_i        (upd_ok && resolve_i.taken && res_info.cls != CTL_NONE),
        .upd_pc_i     (resolve_i.pc),
        .upd_target_i (resolve_i.target)
    );

    bimodal_predictor u_bimodal (
        .clk         (clk),
        .rst         (rst),
        .fetch_pc_i  (fetch_i.pc),
        .taken_o     (bim_taken),
        .upd_i       (upd_ok && res_info.cls == CTL_BRANCH && resolve_i.mispredict),
        .upd_pc_i    (resolve_i.pc),
        .upd_taken_i (resolve_i.taken)
    );

    return_stack u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (upd_ok && res_info.is_call),
        .push_addr_i (resolve_i.pc + INST_STEP),
        .pop_i       (upd_ok && res_info.is_ret),
        .top_valid_o (ras_valid),
        .top_o       (ras_top)
    );

    next_pc_select u_next_pc (
        .fetch_i      (fetch_i),
        .info_i       (fetch_info),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .bim_taken_i  (bim_taken),
        .ras_valid_i  (ras_valid),
        .ras_top_i    (ras_top),
        .suppress_i   (stall_i || flush_i),
        .pred_o       (pred_o)
    );

    // global history, restored from the snapshot on flush
    always_ff @(posedge clk) begin
        if (rst) begin
            hist_q <= '0;
        end else if (flush_i) begin
            hist_q <= resolve_i.history;
        end else if (upd_ok) begin
            hist_q <= {hist_q[`BPU_HIST_W-2:0], resolve_i.taken};
        end
    end

    assign history_o = hist_q;

endmodule

// File: next_pc_select.sv
`timescale 1ns/10ps
`include "bpu_defines.svh"

module next_pc_select (
    input  bpu_pkg::fetch_t      fetch_i,
    input  bpu_pkg::inst_info_t  info_i,
    input  logic                 btb_hit_i,
    input  logic [`BPU_XLEN-1:0] btb_target_i,
    input  logic                 bim_taken_i,
    input  logic                 ras_valid_i,
    input  logic [`BPU_XLEN-1:0] ras_top_i,
    input  logic                 suppress_i,
    output bpu_pkg::prediction_t pred_o
);
    import bpu_pkg::*;

    localparam logic [`BPU_XLEN-1:0] INST_STEP = 4;

    logic [`BPU_XLEN-1:0] seq_pc;

    assign seq_pc = fetch_i.pc + INST_STEP;

    always_comb begin
        pred_o.is_ctl = 1'b0;
        pred_o.taken  = 1'b0;
        pred_o.target = seq_pc;
        if (!suppress_i) begin
            case (info_i.cls)
                CTL_RET: begin
                    pred_o.is_ctl = 1'b1;
                    pred_o.taken  = 1'b1;
                    if (ras_valid_i) begin
                        pred_o.target = ras_top_i;
                    end else if (btb_hit_i) begin
                        pred_o.target = btb_target_i;
                    end else begin
                        pred_o.target = '0;
                    end
                end
                // indirect target only known from the btb
                CTL_JALR, CTL_CALL_JALR: begin
                    pred_o.is_ctl = 1'b1;
                    pred_o.taken  = btb_hit_i;
                    if (btb_hit_i) begin
                        pred_o.target = btb_target_i;
                    end
                end
                CTL_JAL: begin
                    pred_o.is_ctl = 1'b1;
                    pred_o.taken  = 1'b1;
                    pred_o.target = fetch_i.pc + info_i.jal_off;
                end
                CTL_BRANCH: begin
                    pred_o.is_ctl = 1'b1;
                    pred_o.taken  = bim_taken_i;
                    if (bim_taken_i) begin
                        pred_o.target = btb_hit_i ? btb_target_i
                                                  : fetch_i.pc + info_i.br_off;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: return_stack.sv
`timescale 1ns/10ps
`include "bpu_defines.svh"

module return_stack (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 push_i,
    input  logic [`BPU_XLEN-1:0] push_addr_i,
    input  logic                 pop_i,

    output logic                 top_valid_o,
    output logic [`BPU_XLEN-1:0] top_o
);

    localparam int IDX_W = $clog2(`BPU_RAS_DEPTH);
    // one extra bit so a full stack can be told from an empty one
    localparam int PTR_W = IDX_W + 1;
    localparam logic [PTR_W-1:0] FULL = PTR_W'(`BPU_RAS_DEPTH);

    logic [`BPU_XLEN-1:0] stack_q [`BPU_RAS_DEPTH];
    logic [PTR_W-1:0]     ptr_q;
    logic [PTR_W-1:0]     ptr_d;
    logic [IDX_W-1:0]     wr_idx;
    logic [IDX_W-1:0]     top_idx;

    always_comb begin
        wr_idx = ptr_q[IDX_W-1:0];
        ptr_d  = ptr_q;
        if (push_i) begin
            if (ptr_q == FULL) begin
                // overflow wraps to the bottom
                wr_idx = '0;
                ptr_d  = PTR_W'(1);
            end else begin
                ptr_d = ptr_q + 1'b1;
            end
        end else if (pop_i && ptr_q != '0) begin
            ptr_d = ptr_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[wr_idx] <= push_addr_i;
        end
    end

    // entry just below the pointer
    assign top_idx     = ptr_q[IDX_W-1:0] - 1'b1;
    assign top_o       = stack_q[top_idx];
    assign top_valid_o = (ptr_q != '0);

endmodule

// File: bimodal_predictor.sv
`timescale 1ns/10ps
`include "bpu_defines.svh"

module bimodal_predictor (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [`BPU_XLEN-1:0] fetch_pc_i,
    output logic                 taken_o,

    input  logic                 upd_i,
    input  logic [`BPU_XLEN-1:0] upd_pc_i,
    input  logic                 upd_taken_i
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(`BPU_BIM_DEPTH);

    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] upd_idx;
    counter_t         fetch_cnt;
    counter_t         upd_cnt;
    counter_t         next_cnt;

    assign fetch_idx = fetch_pc_i[`BPU_BIM_IDX_HI:`BPU_BIM_IDX_LO];
    assign upd_idx   = upd_pc_i[`BPU_BIM_IDX_HI:`BPU_BIM_IDX_LO];

    // port b reads the counter being trained
    pred_table #(
        .DEPTH       (`BPU_BIM_DEPTH),
        .entry_t     (counter_t),
        .RESET_ENTRY (`BPU_CNT_RESET)
    ) u_table (
        .clk        (clk),
        .rst        (rst),
        .rd_a_idx_i (fetch_idx),
        .rd_a_o     (fetch_cnt),
        .rd_b_idx_i (upd_idx),
        .rd_b_o     (upd_cnt),
        .we_i       (upd_i),
        .wr_idx_i   (upd_idx),
        .wr_data_i  (next_cnt)
    );

    // one step toward the outcome, saturating
    always_comb begin
        next_cnt = upd_cnt;
        if (upd_taken_i && upd_cnt != 2'b11) begin
            next_cnt = upd_cnt + 2'b01;
        end else if (!upd_taken_i && upd_cnt != 2'b00) begin
            next_cnt = upd_cnt - 2'b01;
        end
    end

    assign taken_o = fetch_cnt[1];

endmodule

// File: btb.sv
`timescale 1ns/10ps
`include "bpu_defines.svh"

module btb (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [`BPU_XLEN-1:0] fetch_pc_i,
    output logic                 hit_o,
    output logic [`BPU_XLEN-1:0] target_o,

    input  logic                 upd_i,
    input  logic [`BPU_XLEN-1:0] upd_pc_i,
    input  logic [`BPU_XLEN-1:0] upd_target_i
);
    import bpu_pkg::*;

    localparam int IDX_W = $clog2(`BPU_BTB_DEPTH);

    logic [IDX_W-1:0]          rd_idx;
    logic [IDX_W-1:0]          wr_idx;
    logic [`BPU_BTB_TAG_W-1:0] fetch_tag;
    btb_entry_t                rd_entry;
    btb_entry_t                wr_entry;

    assign rd_idx    = fetch_pc_i[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
    assign fetch_tag = fetch_pc_i[`BPU_XLEN-1:`BPU_BTB_TAG_LO];
    assign wr_idx    = upd_pc_i[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];

    // new entry from the resolved pc
    assign wr_entry.valid  = 1'b1;
    assign wr_entry.tag    = upd_pc_i[`BPU_XLEN-1:`BPU_BTB_TAG_LO];
    assign wr_entry.target = upd_target_i;

    pred_table #(
        .DEPTH       (`BPU_BTB_DEPTH),
        .entry_t     (btb_entry_t),
        .RESET_ENTRY ('0)
    ) u_table (
        .clk        (clk),
        .rst        (rst),
        .rd_a_idx_i (rd_idx),
        .rd_a_o     (rd_entry),
        .rd_b_idx_i ('0),
        .rd_b_o     (),
        .we_i       (upd_i),
        .wr_idx_i   (wr_idx),
        .wr_data_i  (wr_entry)
    );

    assign hit_o    = rd_entry.valid && (rd_entry.tag == fetch_tag);
    assign target_o = rd_entry.target;

endmodule

// File: pred_table.sv
`timescale 1ns/10ps

module pred_table #(
    parameter int       DEPTH       = 256,
    parameter type      entry_t     = logic [1:0],
    parameter entry_t   RESET_ENTRY = '0
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [$clog2(DEPTH)-1:0] rd_a_idx_i,
    output entry_t                   rd_a_o,

    input  logic [$clog2(DEPTH)-1:0] rd_b_idx_i,
    output entry_t                   rd_b_o,

    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    // every entry returns to its initial value on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_ENTRY;
            end
        end else if (we_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // asynchronous reads
    assign rd_a_o = mem[rd_a_idx_i];
    assign rd_b_o = mem[rd_b_idx_i];

endmodule

// File: inst_classify.sv
`timescale 1ns/10ps
`include "bpu_defines.svh"

module inst_classify (
    input  logic [`BPU_XLEN-1:0] inst_i,
    output bpu_pkg::inst_info_t  info_o
);
    import bpu_pkg::*;

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    always_comb begin
        // b-type and j-type immediates, sign extended
        info_o.br_off = {
            {(`BPU_XLEN-12){inst_i[31]}},
            inst_i[7],
            inst_i[30:25],
            inst_i[11:8],
            1'b0
        };
        info_o.jal_off = {
            {(`BPU_XLEN-20){inst_i[31]}},
            inst_i[19:12],
            inst_i[20],
            inst_i[30:21],
            1'b0
        };
        info_o.cls     = CTL_NONE;
        info_o.is_call = 1'b0;
        info_o.is_ret  = 1'b0;
        case (opcode)
            `BPU_OP_BRANCH: begin
                info_o.cls = CTL_BRANCH;
            end
            `BPU_OP_JAL: begin
                info_o.cls     = CTL_JAL;
                info_o.is_call = 1'b1;
            end
            `BPU_OP_JALR: begin
                if (rd == 5'd0 && rs1 == `BPU_LINK_REG) begin
                    info_o.cls    = CTL_RET;
                    info_o.is_ret = 1'b1;
                end else if (rd != 5'd0) begin
                    info_o.cls     = CTL_CALL_JALR;
                    info_o.is_call = 1'b1;
                end else begin
                    info_o.cls = CTL_JALR;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: bpu_pkg.sv
`include "bpu_defines.svh"

package bpu_pkg;

    // control-transfer class of one instruction
    typedef enum logic [2:0] {
        CTL_NONE,
        CTL_BRANCH,
        CTL_JAL,
        CTL_JALR,
        CTL_CALL_JALR,
        CTL_RET
    } ctl_class_e;

    typedef struct packed {
        ctl_class_e           cls;
        logic                 is_call;
        logic                 is_ret;
        logic [`BPU_XLEN-1:0] br_off;
        logic [`BPU_XLEN-1:0] jal_off;
    } inst_info_t;

    typedef struct packed {
        logic [`BPU_XLEN-1:0] pc;
        logic [`BPU_XLEN-1:0] inst;
    } fetch_t;

    // feedback from execute
    typedef struct packed {
        logic                   valid;
        logic                   taken;
        logic                   mispredict;
        logic [`BPU_XLEN-1:0]   pc;
        logic [`BPU_XLEN-1:0]   inst;
        logic [`BPU_XLEN-1:0]   target;
        logic [`BPU_HIST_W-1:0] history;
    } resolve_t;

    typedef struct packed {
        logic                     valid;
        logic [`BPU_BTB_TAG_W-1:0] tag;
        logic [`BPU_XLEN-1:0]     target;
    } btb_entry_t;

    typedef logic [1:0] counter_t;

    typedef struct packed {
        logic                 is_ctl;
        logic                 taken;
        logic [`BPU_XLEN-1:0] target;
    } prediction_t;

endpackage

// File: bpu_defines.svh
`ifndef BPU_DEFINES_SVH
`define BPU_DEFINES_SVH

// datapath
`define BPU_XLEN        32
`define BPU_HIST_W      16

// branch target buffer, indexed by pc[9:2], tag from pc[31:18]
`define BPU_BTB_DEPTH   256
`define BPU_BTB_TAG_W   14
`define BPU_BTB_IDX_HI  9
`define BPU_BTB_IDX_LO  2
`define BPU_BTB_TAG_LO  18

// bimodal counters, indexed by pc[9:1]
`define BPU_BIM_DEPTH   512
`define BPU_BIM_IDX_HI  9
`define BPU_BIM_IDX_LO  1
`define BPU_CNT_RESET   2'b01

`define BPU_RAS_DEPTH   32

// rv32 opcodes and link register
`define BPU_OP_JAL      7'b1101111
`define BPU_OP_JALR     7'b1100111
`define BPU_OP_BRANCH   7'b1100011
`define BPU_LINK_REG    5'd1

`endif
